/* mulPkg.sv */
`default_nettype none

package mulPkg;

    // operand and product widths
    localparam int dataWidth = 32;
    localparam int prodWidth = 2 * dataWidth;

    // radix-4 booth over 33-bit operands
    localparam int ppCount = dataWidth / 2 + 1;

    // carries handed from one wallace column to the next
    localparam int carryCount = 14;

    // apb register map, byte offsets
    localparam int addrWidth = 5;
    localparam logic [addrWidth-1:0] regOpA = 5'd0;
    localparam logic [addrWidth-1:0] regOpB = 5'd4;
    localparam logic [addrWidth-1:0] regCtrl = 5'd8;
    localparam logic [addrWidth-1:0] regStatus = 5'd12;
    localparam logic [addrWidth-1:0] regResLo = 5'd16;
    localparam logic [addrWidth-1:0] regResHi = 5'd20;

    // control word bits, start self-clears
    localparam int ctrlStart = 0;
    localparam int ctrlSigned = 1;

    // status word bits
    localparam int statusBusy = 0;
    localparam int statusDone = 1;

    // cycles from start to done
    localparam int coreLatency = 2;

endpackage

`default_nettype wire

/* mulIf.sv */
`timescale 1ns/10ps
`default_nettype none

interface mulIf;

    // operation towards the core
    logic [mulPkg::dataWidth-1:0] opA;
    logic [mulPkg::dataWidth-1:0] opB;
    logic                         isSigned;
    logic                         start;

    // result back from the core
    logic [mulPkg::prodWidth-1:0] product;
    logic                         done;

    modport regs (
        output opA, opB, isSigned, start,
        input  product, done
    );

    modport core (
        input  opA, opB, isSigned, start,
        output product, done
    );

endinterface

`default_nettype wire

/* boothEncoder.sv */
`timescale 1ns/10ps
`default_nettype none

module boothEncoder (
    input  logic [mulPkg::dataWidth-1:0]                        opA,
    input  logic [mulPkg::dataWidth-1:0]                        opB,
    input  logic                                                isSigned,
    output logic [mulPkg::prodWidth-1:0][mulPkg::ppCount-1:0]   pp
);

    logic                           aSign;
    logic [mulPkg::dataWidth+1:0]   aOne;
    logic [mulPkg::dataWidth+1:0]   aTwo;
    logic [mulPkg::dataWidth:0]     bExt;
    logic [mulPkg::ppCount-2:0]     neg;
    logic [mulPkg::prodWidth-1:0]   row [mulPkg::ppCount];

    // multiplicand as 34-bit signed, once and twice
    assign aSign = isSigned & opA[mulPkg::dataWidth-1];
    assign aOne = {{2{aSign}}, opA};
    assign aTwo = {aSign, opA, 1'b0};

    // implicit zero below bit 0 of the multiplier
    assign bExt = {opB, 1'b0};

    always_comb begin
        logic [2:0]                   grp;
        logic [mulPkg::dataWidth+1:0] mag;
        logic [mulPkg::dataWidth+1:0] part;
        logic [mulPkg::dataWidth+3:0] field;
        for (int i = 0; i < mulPkg::ppCount - 1; i++) begin
            grp = bExt[2*i +: 3];
            neg[i] = grp[2] & ~(grp[1] & grp[0]);
            if (grp[1] ^ grp[0]) begin
                mag = aOne;
            end else if (grp[2] ^ grp[1]) begin
                mag = aTwo;
            end else begin
                mag = '0;
            end
            part = neg[i] ? ~mag : mag;
            // sign extension replaced by a constant folded into the rows
            if (i == 0) begin
                field = {~part[mulPkg::dataWidth+1], part[mulPkg::dataWidth+1], part};
            end else begin
                field = {2'b01, ~part[mulPkg::dataWidth+1], part[mulPkg::dataWidth:0]};
            end
            row[i] = {{(mulPkg::prodWidth - mulPkg::dataWidth - 4){1'b0}}, field} << (2*i);
        end
        // top group only ever adds opA, and only for unsigned with opB msb set
        row[mulPkg::ppCount-1] = {
            opA & {mulPkg::dataWidth{opB[mulPkg::dataWidth-1] & ~isSigned}},
            {mulPkg::dataWidth{1'b0}}
        };
        // +1 of each negated row sits in the empty low bits of the next row
        for (int i = 1; i < mulPkg::ppCount; i++) begin
            row[i][2*i-2] = neg[i-1];
        end
    end

    // transpose rows into weight columns
    always_comb begin
        for (int j = 0; j < mulPkg::prodWidth; j++) begin
            for (int i = 0; i < mulPkg::ppCount; i++) begin
                pp[j][i] = row[i][j];
            end
        end
    end

endmodule

`default_nettype wire

/* wallaceSlice.sv */
`timescale 1ns/10ps
`default_nettype none

module wallaceSlice (
    input  logic                          mulClk,
    input  logic                          resetn,
    input  logic [mulPkg::ppCount-1:0]    in,
    input  logic [mulPkg::carryCount-1:0] carryIn,
    output logic [mulPkg::carryCount-1:0] carryOut,
    output logic                          sum,
    output logic                          carry
);

    logic [4:0]  s1;
    logic [4:0]  c1;
    logic [11:0] in2;
    logic [3:0]  s2;
    logic [3:0]  c2;
    logic [3:0]  s2Reg;
    logic [3:0]  carryReg;
    logic [5:0]  in3;
    logic [1:0]  s3;
    logic [1:0]  c3;
    logic [5:0]  in4;
    logic [1:0]  s4;
    logic [1:0]  c4;
    logic        s5;
    logic        c5;

    // returns {carry, sum}
    function automatic logic [1:0] fullAdd(input logic a, input logic b, input logic c);
        return {(a & b) | (a & c) | (b & c), a ^ b ^ c};
    endfunction

    // layer one on the upper fifteen inputs
    for (genvar i = 0; i < 5; i++) begin : gLayer1
        assign {c1[i], s1[i]} = fullAdd(in[3*i+4], in[3*i+3], in[3*i+2]);
    end

    // layer two takes the carries of layer one from the column below
    assign in2 = {s1, in[1:0], carryIn[4:0]};
    for (genvar i = 0; i < 4; i++) begin : gLayer2
        assign {c2[i], s2[i]} = fullAdd(in2[3*i+2], in2[3*i+1], in2[3*i]);
    end

    // pipeline cut
    always_ff @(posedge mulClk) begin
        if (!resetn) begin
            s2Reg <= '0;
            carryReg <= '0;
        end else begin
            s2Reg <= s2;
            carryReg <= carryIn[8:5];
        end
    end

    assign in3 = {s2Reg, carryReg[1:0]};
    for (genvar i = 0; i < 2; i++) begin : gLayer3
        assign {c3[i], s3[i]} = fullAdd(in3[3*i+2], in3[3*i+1], in3[3*i]);
    end

    // layer-three carries from below are already past the cut
    assign in4 = {s3, carryIn[10:9], carryReg[3:2]};
    for (genvar i = 0; i < 2; i++) begin : gLayer4
        assign {c4[i], s4[i]} = fullAdd(in4[3*i+2], in4[3*i+1], in4[3*i]);
    end

    assign {c5, s5} = fullAdd(s4[1], s4[0], carryIn[11]);
    assign {carry, sum} = fullAdd(s5, carryIn[13], carryIn[12]);

    assign carryOut = {c5, c4, c3, c2, c1};

endmodule

`default_nettype wire

/* wallaceArray.sv */
`timescale 1ns/10ps
`default_nettype none

module wallaceArray (
    input  logic                                                mulClk,
    input  logic                                                resetn,
    input  logic [mulPkg::prodWidth-1:0][mulPkg::ppCount-1:0]   pp,
    output logic [mulPkg::prodWidth-1:0]                        product
);

    // entry k feeds column k; the top entry falls off the product
    logic [mulPkg::prodWidth:0][mulPkg::carryCount-1:0] carryChain;
    logic [mulPkg::prodWidth-1:0]                       sumVec;
    logic [mulPkg::prodWidth-1:0]                       carryVec;
    logic [mulPkg::prodWidth-1:0]                       total;

    assign carryChain[0] = '0;

    for (genvar k = 0; k < mulPkg::prodWidth; k++) begin : gCol
        wallaceSlice i_slice (
            .mulClk   (mulClk),
            .resetn   (resetn),
            .in       (pp[k]),
            .carryIn  (carryChain[k]),
            .carryOut (carryChain[k+1]),
            .sum      (sumVec[k]),
            .carry    (carryVec[k])
        );
    end

    // carry of column k weighs one place more
    assign total = sumVec + {carryVec[mulPkg::prodWidth-2:0], 1'b0};

    // second pipeline stage
    always_ff @(posedge mulClk) begin
        product <= total;
    end

endmodule

`default_nettype wire

/* mulCore.sv */
`timescale 1ns/10ps
`default_nettype none

module mulCore (
    input  logic    mulClk,
    input  logic    resetn,
    mulIf.core      bus
);

    logic [mulPkg::prodWidth-1:0][mulPkg::ppCount-1:0] pp;
    logic [mulPkg::coreLatency-1:0]                    validPipe;

    // operand extension follows the mode bit inside the encoder
    boothEncoder i_booth (
        .opA      (bus.opA),
        .opB      (bus.opB),
        .isSigned (bus.isSigned),
        .pp       (pp)
    );

    wallaceArray i_array (
        .mulClk  (mulClk),
        .resetn  (resetn),
        .pp      (pp),
        .product (bus.product)
    );

    // one valid bit per register stage of the array
    always_ff @(posedge mulClk) begin
        if (!resetn) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[mulPkg::coreLatency-2:0], bus.start};
        end
    end

    assign bus.done = validPipe[mulPkg::coreLatency-1];

endmodule

`default_nettype wire

/* mulApb.sv */
`timescale 1ns/10ps
`default_nettype none

module mulApb (
    input  logic                         mulClk,
    input  logic                         resetn,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [mulPkg::addrWidth-1:0] paddr,
    input  logic [mulPkg::dataWidth-1:0] pwdata,
    output logic [mulPkg::dataWidth-1:0] prdata,
    output logic                         pready,
    output logic                         pslverr,
    mulIf.regs                           bus
);

    logic [mulPkg::dataWidth-1:0] opA;
    logic [mulPkg::dataWidth-1:0] opB;
    logic                         signedMode;
    logic                         startPulse;
    logic                         busy;
    logic                         doneFlag;
    logic [mulPkg::prodWidth-1:0] result;
    logic                         startReq;
    logic                         wrEn;

    assign startReq = psel & penable & pwrite & (paddr == mulPkg::regCtrl)
                    & pwdata[mulPkg::ctrlStart];

    // a start while busy is held off until the running op reports done
    assign pready = ~(startReq & busy & ~bus.done);
    assign pslverr = 1'b0;
    assign wrEn = psel & penable & pwrite & pready;

    always_ff @(posedge mulClk) begin
        if (wrEn && paddr == mulPkg::regOpA) begin
            opA <= pwdata;
        end
        if (wrEn && paddr == mulPkg::regOpB) begin
            opB <= pwdata;
        end
    end

    always_ff @(posedge mulClk) begin
        if (!resetn) begin
            signedMode <= 1'b0;
            startPulse <= 1'b0;
            busy <= 1'b0;
            doneFlag <= 1'b0;
        end else begin
            startPulse <= 1'b0;
            if (wrEn && paddr == mulPkg::regCtrl) begin
                signedMode <= pwdata[mulPkg::ctrlSigned];
            end
            // new start wins over a done in the same cycle
            if (wrEn && startReq) begin
                startPulse <= 1'b1;
                busy <= 1'b1;
                doneFlag <= 1'b0;
            end else if (bus.done) begin
                busy <= 1'b0;
                doneFlag <= 1'b1;
            end
        end
    end

    always_ff @(posedge mulClk) begin
        if (!resetn) begin
            result <= '0;
        end else if (bus.done) begin
            result <= bus.product;
        end
    end

    assign bus.opA = opA;
    assign bus.opB = opB;
    assign bus.isSigned = signedMode;
    assign bus.start = startPulse;

    // read mux, no wait state
    always_comb begin
        prdata = '0;
        case (paddr)
            mulPkg::regOpA:   prdata = opA;
            mulPkg::regOpB:   prdata = opB;
            mulPkg::regCtrl:  prdata[mulPkg::ctrlSigned] = signedMode;
            mulPkg::regStatus: begin
                prdata[mulPkg::statusBusy] = busy;
                prdata[mulPkg::statusDone] = doneFlag;
            end
            mulPkg::regResLo: prdata = result[mulPkg::dataWidth-1:0];
            mulPkg::regResHi: prdata = result[mulPkg::prodWidth-1:mulPkg::dataWidth];
            default:          prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* mulTop.sv */
`timescale 1ns/10ps
`default_nettype none

module mulTop (
    input  logic                         mulClk,
    input  logic                         resetn,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [mulPkg::addrWidth-1:0] paddr,
    input  logic [mulPkg::dataWidth-1:0] pwdata,
    output logic [mulPkg::dataWidth-1:0] prdata,
    output logic                         pready,
    output logic                         pslverr
);

    // operation and result between register block and core
    mulIf bus ();

    mulApb i_apb (
        .mulClk  (mulClk),
        .resetn  (resetn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .bus     (bus)
    );

    mulCore i_core (
        .mulClk (mulClk),
        .resetn (resetn),
        .bus    (bus)
    );

endmodule

`default_nettype wire

/* mulChk.sv */
`timescale 1ns/10ps
`default_nettype none

module mulChk (
    input logic mulClk,
    input logic resetn,
    input logic start,
    input logic done,
    input logic pready
);

    // core latency as seen from the register block
    startToDone: assert property (@(posedge mulClk) disable iff (!resetn)
        start |-> ##2 done)
        else $error("done missing two cycles after start");

    doneFromStart: assert property (@(posedge mulClk) disable iff (!resetn)
        done |-> $past(start, 2))
        else $error("done without a start two cycles earlier");

    startIsPulse: assert property (@(posedge mulClk) disable iff (!resetn)
        start |=> !start)
        else $error("start held for more than one cycle");

    // a stalled start is released once the running op is done
    stallReleased: assert property (@(posedge mulClk) disable iff (!resetn)
        !pready && $past(!pready) |=> pready)
        else $error("pready held low past the core latency");

endmodule

// done arrives from the core through the interface
bind mulApb mulChk i_chk (
    .mulClk  (mulClk),
    .resetn  (resetn),
    .start   (startPulse),
    .done    (bus.done),
    .pready  (pready)
);

`default_nettype wire

/* tbMul.sv */
`timescale 1ns/10ps
`default_nettype none

module tbMul;

    localparam int clkPeriod = 40;
    localparam int numRandom = 300;
    localparam int cyclesPerTest = 40;
    // random runs, corner pairs in both modes, a few directed ops
    localparam int numTests = 2 * numRandom + 2 * 25 + 8;
    localparam int watchdogCycles = numTests * cyclesPerTest + 16;

    logic                         mulClk;
    logic                         resetn;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    logic [mulPkg::addrWidth-1:0] paddr;
    logic [mulPkg::dataWidth-1:0] pwdata;
    logic [mulPkg::dataWidth-1:0] prdata;
    logic                         pready;
    logic                         pslverr;

    logic [15:0] lfsrState;
    int          lastWaits;
    int          failCount;
    logic [31:0] corners [5];

    mulTop i_dut (
        .mulClk  (mulClk),
        .resetn  (resetn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        mulClk = 1'b0;
        forever #(clkPeriod / 2) mulClk = ~mulClk;
    end

    // taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic randBits(input int n, output logic [31:0] w);
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            w[i] = lfsrState[0];
        end
    endtask

    // low 64 bits of the extended product hold the signed result too
    function automatic logic [63:0] refProduct(input logic [31:0] a, input logic [31:0] b,
                                               input logic sgn);
        logic [63:0] ea;
        logic [63:0] eb;
        ea = {{32{sgn & a[31]}}, a};
        eb = {{32{sgn & b[31]}}, b};
        return ea * eb;
    endfunction

    function automatic logic [31:0] ctrlWord(input logic start, input logic sgn);
        logic [31:0] w;
        w = '0;
        w[mulPkg::ctrlStart] = start;
        w[mulPkg::ctrlSigned] = sgn;
        return w;
    endfunction

    task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
        if (actual !== expected) begin
            failCount++;
            $display("ERROR at %0t ns: %s, got 0x%016h expected 0x%016h",
                     $time, what, actual, expected);
            $display("sim failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // entered 2 ns after an edge with the setup phase on the bus
    task automatic accessPhase(output logic [31:0] rdata);
        @(posedge mulClk);
        #2;
        penable = 1'b1;
        lastWaits = 0;
        @(negedge mulClk);
        while (!pready) begin
            lastWaits++;
            @(negedge mulClk);
        end
        rdata = prdata;
        checkValue({63'b0, pslverr}, 64'd0, "pslverr in access phase");
        @(posedge mulClk);
        #2;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apbWrite(input logic [mulPkg::addrWidth-1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        psel = 1'b1;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        accessPhase(unused);
    endtask

    task automatic apbRead(input logic [mulPkg::addrWidth-1:0] addr, output logic [31:0] data);
        psel = 1'b1;
        pwrite = 1'b0;
        paddr = addr;
        accessPhase(data);
    endtask

    task automatic waitDone();
        logic [31:0] st;
        st = '0;
        while (!st[mulPkg::statusDone]) begin
            apbRead(mulPkg::regStatus, st);
        end
    endtask

    task automatic readResult(output logic [63:0] res);
        logic [31:0] lo;
        logic [31:0] hi;
        apbRead(mulPkg::regResLo, lo);
        apbRead(mulPkg::regResHi, hi);
        res = {hi, lo};
    endtask

    task automatic runProduct(input logic [31:0] a, input logic [31:0] b, input logic sgn);
        logic [63:0] res;
        apbWrite(mulPkg::regOpA, a);
        apbWrite(mulPkg::regOpB, b);
        apbWrite(mulPkg::regCtrl, ctrlWord(1'b1, sgn));
        waitDone();
        readResult(res);
        checkValue(res, refProduct(a, b, sgn), sgn ? "signed product" : "unsigned product");
    endtask

    initial begin
        repeat (watchdogCycles) @(posedge mulClk);
        $display("timeout: tests did not complete within %0d cycles", watchdogCycles);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rd;
        logic [31:0] modeBit;
        logic [63:0] res;
        resetn = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        lfsrState = 16'd22594;
        lastWaits = 0;
        failCount = 0;
        corners = '{32'h0, 32'h1, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};
        repeat (16) @(posedge mulClk);
        #2;
        resetn = 1'b1;

        apbRead(mulPkg::regStatus, rd);
        checkValue({32'b0, rd}, 64'd0, "status after reset");
        readResult(res);
        checkValue(res, 64'd0, "result after reset");

        for (int n = 0; n < numRandom; n++) begin
            randBits(32, a);
            randBits(32, b);
            runProduct(a, b, 1'b0);
        end
        for (int n = 0; n < numRandom; n++) begin
            randBits(32, a);
            randBits(32, b);
            runProduct(a, b, 1'b1);
        end
        for (int m = 0; m < 2; m++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    runProduct(corners[i], corners[j], m == 1);
                end
            end
        end

        // unsigned start then signed start, back to back
        randBits(32, a);
        randBits(32, b);
        a[31] = 1'b1;
        b[31] = 1'b0;
        b[0] = 1'b1;
        apbWrite(mulPkg::regOpA, a);
        apbWrite(mulPkg::regOpB, b);
        apbWrite(mulPkg::regCtrl, ctrlWord(1'b1, 1'b0));
        apbWrite(mulPkg::regCtrl, ctrlWord(1'b1, 1'b1));
        checkValue({63'b0, lastWaits > 0}, 64'd1, "second start stalled");
        waitDone();
        apbRead(mulPkg::regStatus, rd);
        checkValue({32'b0, rd}, 64'd1 << mulPkg::statusDone, "status after stalled start");
        readResult(res);
        checkValue(res, refProduct(a, b, 1'b1), "stalled start product");

        randBits(32, a);
        randBits(32, b);
        randBits(1, modeBit);
        apbWrite(mulPkg::regOpA, a);
        apbRead(mulPkg::regOpA, rd);
        checkValue({32'b0, rd}, {32'b0, a}, "opA readback");
        apbWrite(mulPkg::regOpB, b);
        apbRead(mulPkg::regOpB, rd);
        checkValue({32'b0, rd}, {32'b0, b}, "opB readback");
        apbWrite(mulPkg::regCtrl, ctrlWord(1'b0, modeBit[0]));
        apbRead(mulPkg::regCtrl, rd);
        checkValue({32'b0, rd}, {32'b0, ctrlWord(1'b0, modeBit[0])}, "ctrl readback");
        apbWrite(mulPkg::regCtrl, ctrlWord(1'b1, 1'b1));
        apbRead(mulPkg::regCtrl, rd);
        checkValue({32'b0, rd}, {32'b0, ctrlWord(1'b0, 1'b1)}, "start bit readback");
        waitDone();

        if (failCount == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
mulPkg.sv
mulIf.sv
boothEncoder.sv
wallaceSlice.sv
wallaceArray.sv
mulCore.sv
mulApb.sv
mulTop.sv
mulChk.sv
tbMul.sv

/* run.sh */
#!/bin/sh
# build and run the multiplier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tbMul -f vlog.f -o simMul

status=0
./obj_dir/simMul > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "sim failed" sim.log || [ "$status" -ne 0 ]; then
    echo "result: FAIL (see sim.log)"
    exit 1
fi
echo "result: PASS"
